// ==== cpu_pkg.sv ====
package cpu_pkg;

    // Datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;

    // Major opcodes
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_system = 7'b1110011;

    // funct3 and funct12 values of the kept instructions
    localparam logic [2:0]  f3_addi    = 3'b000;
    localparam logic [2:0]  f3_priv    = 3'b000;
    localparam logic [11:0] f12_ebreak = 12'h001;

    localparam logic [1:0] axi_resp_okay = 2'b00;

    typedef enum logic [1:0] {
        cmd_nop,
        cmd_add,
        cmd_pass,
        cmd_halt
    } cmd_e;

    typedef struct packed {
        cmd_e                  cmd;
        logic [xlen-1:0]       src1;
        logic [xlen-1:0]       src2;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
    } dec_t;

    typedef enum logic [1:0] {
        cause_none,
        cause_ebreak,
        cause_bus_error
    } halt_cause_e;

    // AXI4-Lite read channels with prot tied to zero
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] data;
        logic [1:0]      resp;
    } axi_r_t;

    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic [xlen-1:0]       data;
    } retire_t;

endpackage

// ==== ifu.sv ====
`timescale 1ns/10ps

module ifu (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     arready,
    input  cpu_pkg::axi_r_t          r,
    input  logic                     halt_req,
    output cpu_pkg::axi_ar_t         ar,
    output logic                     rready,
    output logic [cpu_pkg::xlen-1:0] inst,
    output logic [cpu_pkg::xlen-1:0] inst_pc,
    output logic                     inst_valid,
    output logic                     halted,
    output cpu_pkg::halt_cause_e     halt_cause
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        st_addr,
        st_data,
        st_exec
    } state_e;

    state_e          state;
    logic [xlen-1:0] pc;
    logic            arvalid_q;
    logic            ar_fire;
    logic            r_fire;

    // Next fetch is queued at retire, masked while ebreak is reported
    always_comb begin
        ar.valid = arvalid_q && !halt_req;
        ar.addr  = pc;
    end

    assign ar_fire = ar.valid && arready;
    assign r_fire  = r.valid && rready;
    assign inst_pc = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_addr;
            pc         <= reset_pc;
            arvalid_q  <= 1'b0;
            rready     <= 1'b0;
            inst_valid <= 1'b0;
            halted     <= 1'b0;
            halt_cause <= cause_none;
        end else if (halt_req) begin
            // Drop the queued fetch and stop for good
            arvalid_q  <= 1'b0;
            halted     <= 1'b1;
            halt_cause <= cause_ebreak;
        end else begin
            case (state)
                st_addr: begin
                    if (ar_fire) begin
                        arvalid_q <= 1'b0;
                        rready    <= 1'b1;
                        state     <= st_data;
                    end else if (!halted) begin
                        arvalid_q <= 1'b1;
                    end
                end
                st_data: begin
                    if (r_fire) begin
                        rready <= 1'b0;
                        if (r.resp != axi_resp_okay) begin
                            halted     <= 1'b1;
                            halt_cause <= cause_bus_error;
                            state      <= st_addr;
                        end else begin
                            inst_valid <= 1'b1;
                            state      <= st_exec;
                        end
                    end
                end
                st_exec: begin
                    // Instruction retires on this edge
                    inst_valid <= 1'b0;
                    pc         <= pc + xlen'(4);
                    arvalid_q  <= 1'b1;
                    state      <= st_addr;
                end
                default: begin
                    state <= st_addr;
                end
            endcase
        end
    end

    // Fetched word
    always_ff @(posedge clk) begin
        if (r_fire) begin
            inst <= r.data;
        end
    end

endmodule

// ==== idu.sv ====
`timescale 1ns/10ps

module idu (
    input  logic [cpu_pkg::xlen-1:0]       inst,
    input  logic [cpu_pkg::xlen-1:0]       pc,
    input  logic [cpu_pkg::xlen-1:0]       rdata,
    output logic [cpu_pkg::reg_addr_w-1:0] raddr,
    output cpu_pkg::dec_t                  dec
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {
        imm_n,
        imm_i,
        imm_u
    } imm_e;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [11:0]     funct12;
    imm_e            imm_type;
    logic [xlen-1:0] imm;
    logic            rs1_ren;

    assign opcode  = inst[6:0];
    assign funct3  = inst[14:12];
    assign funct12 = inst[31:20];

    assign raddr = rs1_ren ? inst[19:15] : '0;

    // Immediate format per opcode
    always_comb begin
        case (opcode)
            op_imm:            imm_type = (funct3 == f3_addi) ? imm_i : imm_n;
            op_lui, op_auipc:  imm_type = imm_u;
            default:           imm_type = imm_n;
        endcase
    end

    always_comb begin
        case (imm_type)
            imm_i:   imm = {{(xlen-12){inst[31]}}, inst[31:20]};
            imm_u:   imm = {inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    always_comb begin
        rs1_ren  = 1'b0;
        dec.cmd  = cmd_nop;
        dec.src1 = '0;
        dec.src2 = '0;
        dec.rd   = '0;
        dec.wen  = 1'b0;
        case (opcode)
            op_imm: begin
                // addi only
                if (funct3 == f3_addi) begin
                    rs1_ren  = 1'b1;
                    dec.cmd  = cmd_add;
                    dec.src1 = imm;
                    dec.src2 = rdata;
                    dec.wen  = 1'b1;
                end
            end
            op_lui: begin
                dec.cmd  = cmd_pass;
                dec.src2 = imm;
                dec.wen  = 1'b1;
            end
            op_auipc: begin
                dec.cmd  = cmd_add;
                dec.src1 = pc;
                dec.src2 = imm;
                dec.wen  = 1'b1;
            end
            op_system: begin
                if (funct3 == f3_priv && funct12 == f12_ebreak) begin
                    dec.cmd = cmd_halt;
                end
            end
            default: begin
                dec.cmd = cmd_nop;
            end
        endcase
        if (dec.wen) begin
            dec.rd = inst[11:7];
        end
    end

endmodule

// ==== gpr_file.sv ====
`timescale 1ns/10ps

module gpr_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr,
    input  logic                           wen,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    output logic [cpu_pkg::xlen-1:0]       rdata
);
    import cpu_pkg::*;

    localparam int num_regs = 2 ** reg_addr_w;

    // x0 has no storage
    logic [xlen-1:0] regs [1:num_regs-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

// ==== exu.sv ====
`timescale 1ns/10ps

module exu (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cpu_pkg::dec_t                  dec,
    input  logic                           inst_valid,
    input  logic [cpu_pkg::xlen-1:0]       inst_pc,
    output logic                           wen,
    output logic [cpu_pkg::reg_addr_w-1:0] waddr,
    output logic [cpu_pkg::xlen-1:0]       wdata,
    output cpu_pkg::retire_t               retire,
    output logic                           halt_req
);
    import cpu_pkg::*;

    logic [xlen-1:0] result;

    always_comb begin
        case (dec.cmd)
            cmd_add:  result = dec.src1 + dec.src2;
            cmd_pass: result = dec.src2;
            default:  result = '0;
        endcase
    end

    // Writeback on the closing edge of the inst_valid cycle
    assign wen   = inst_valid && dec.wen;
    assign waddr = dec.rd;
    assign wdata = result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire.valid <= 1'b0;
            halt_req     <= 1'b0;
        end else begin
            retire.valid <= inst_valid;
            halt_req     <= inst_valid && (dec.cmd == cmd_halt);
            if (inst_valid) begin
                retire.pc   <= inst_pc;
                retire.rd   <= dec.rd;
                retire.wen  <= dec.wen;
                retire.data <= result;
            end
        end
    end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/10ps

module cpu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 arready,
    input  cpu_pkg::axi_r_t      r,
    output cpu_pkg::axi_ar_t     ar,
    output logic                 rready,
    output cpu_pkg::retire_t     retire,
    output logic                 halted,
    output cpu_pkg::halt_cause_e halt_cause
);
    import cpu_pkg::*;

    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       inst_pc;
    logic                  inst_valid;
    logic [reg_addr_w-1:0] raddr;
    logic [xlen-1:0]       rdata;
    dec_t                  dec;
    logic                  gpr_wen;
    logic [reg_addr_w-1:0] gpr_waddr;
    logic [xlen-1:0]       gpr_wdata;
    logic                  halt_req;

    ifu u_ifu (
        .clk        (clk),
        .rst_n      (rst_n),
        .arready    (arready),
        .r          (r),
        .halt_req   (halt_req),
        .ar         (ar),
        .rready     (rready),
        .inst       (inst),
        .inst_pc    (inst_pc),
        .inst_valid (inst_valid),
        .halted     (halted),
        .halt_cause (halt_cause)
    );

    idu u_idu (
        .inst  (inst),
        .pc    (inst_pc),
        .rdata (rdata),
        .raddr (raddr),
        .dec   (dec)
    );

    gpr_file u_gpr_file (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (raddr),
        .wen   (gpr_wen),
        .waddr (gpr_waddr),
        .wdata (gpr_wdata),
        .rdata (rdata)
    );

    exu u_exu (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .wen        (gpr_wen),
        .waddr      (gpr_waddr),
        .wdata      (gpr_wdata),
        .retire     (retire),
        .halt_req   (halt_req)
    );

endmodule

// ==== tb_tasks.svh ====
localparam int          imm_opc     = 'h13;
localparam int          reg_opc     = 'h33;
localparam int          lui_opc     = 'h37;
localparam int          auipc_opc   = 'h17;
localparam logic [31:0] ebreak_insn = 32'h0010_0073;

task automatic end_with_failure();
    errors++;
    $display("RESULT: FAIL");
    $fatal(1);
endtask

task automatic report_mismatch(input string what);
    $display("ERR @%0t: %s", $time, what);
    end_with_failure();
endtask

function automatic logic [31:0] itype_insn(input int opc, input int f3, input int rd,
                                           input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] addi_insn(input int rd, input int rs1, input int imm);
    return itype_insn(imm_opc, 0, rd, rs1, imm);
endfunction

function automatic logic [31:0] upper_insn(input int opc, input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], opc[6:0]};
endfunction

// Expected retire of one instruction under the addi/lui/auipc/ebreak rules
task automatic model_step(input logic [31:0] pc, input logic [31:0] word,
                          output retire_t want, output bit stop);
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    imm_i      = {{20{word[31]}}, word[31:20]};
    imm_u      = {word[31:12], 12'h000};
    want       = '0;
    want.valid = 1'b1;
    want.pc    = pc;
    want.rd    = word[11:7];
    want.wen   = 1'b1;
    stop       = 1'b0;
    if (word[6:0] == 7'h13 && word[14:12] == 3'b000)
        want.data = model_regs[word[19:15]] + imm_i;
    else if (word[6:0] == 7'h37)
        want.data = imm_u;
    else if (word[6:0] == 7'h17)
        want.data = pc + imm_u;
    else begin
        want.wen = 1'b0;
        stop = word[6:0] == 7'h73 && word[14:12] == 3'b000 && word[31:20] == 12'h001;
    end
    if (want.wen && want.rd != 5'd0)
        model_regs[want.rd] = want.data;
endtask

task automatic apply_reset();
    @(posedge clk);
    #drive_delay;
    rst_n = 1'b0;
    got_q.delete();
    ar_after_halt = 1'b0;
    repeat (2) @(posedge clk);
    #drive_delay;
    assert (!ar.valid && !rready && !retire.valid && !halted && halt_cause == cause_none)
        else report_mismatch("outputs not cleared by reset");
    rst_n = 1'b1;
endtask

task automatic check_retire(input int idx, input retire_t got, input retire_t want);
    assert (got.pc == want.pc && got.wen == want.wen && got.data == want.data)
        else report_mismatch($sformatf("retire %0d pc %h wen %b data %h, expected %h %b %h",
                             idx, got.pc, got.wen, got.data, want.pc, want.wen, want.data));
    assert (!want.wen || got.rd == want.rd)
        else report_mismatch($sformatf("retire %0d rd %0d, expected %0d", idx, got.rd, want.rd));
endtask

// Loads prog, runs it until the core halts and checks every retire
task automatic run_program(input int err_at, input bit slow);
    retire_t     want;
    bit          stop;
    logic [31:0] pc;
    halt_cause_e exp_cause;
    int          limit;
    int          waited;
    for (int i = 0; i < mem_words; i++)
        mem[i] = (i < prog.size()) ? prog[i] : ~(reset_pc + 32'(4 * i));
    foreach (model_regs[i])
        model_regs[i] = '0;
    err_index  = err_at;
    use_delays = slow;
    exp_q.delete();
    exp_cause = cause_none;
    pc = reset_pc;
    for (int i = 0; i < prog.size() && exp_cause == cause_none; i++) begin
        if (i == err_at) begin
            exp_cause = cause_bus_error;
        end else begin
            model_step(pc, prog[i], want, stop);
            exp_q.push_back(want);
            pc = pc + 32'd4;
            if (stop)
                exp_cause = cause_ebreak;
        end
    end
    if (exp_cause == cause_ebreak)
        fetch_stop_count = exp_q.size();
    else
        fetch_stop_count = -1;
    apply_reset();
    limit  = (exp_q.size() + 2) * worst_inst_cycles;
    waited = 0;
    while (!halted && waited < limit) begin
        @(negedge clk);
        waited++;
    end
    if (!halted) begin
        $display("Timeout: core did not halt within %0d cycles", limit);
        end_with_failure();
    end
    // Idle a while to catch late fetches or retires
    repeat (8) @(negedge clk);
    assert (got_q.size() == exp_q.size())
        else report_mismatch($sformatf("%0d retires, expected %0d", got_q.size(), exp_q.size()));
    foreach (exp_q[i])
        check_retire(i, got_q[i], exp_q[i]);
    assert (halt_cause == exp_cause)
        else report_mismatch($sformatf("halt cause %s, expected %s",
                             halt_cause.name(), exp_cause.name()));
    assert (!ar_after_halt)
        else report_mismatch("ar.valid raised after ebreak retire or halt");
endtask

task automatic addi_chain();
    prog = {addi_insn(1, 0, 5), addi_insn(2, 1, -7), addi_insn(3, 2, 2047),
            addi_insn(4, 3, -2048), addi_insn(1, 1, 1), ebreak_insn};
    run_program(-1, 1'b0);
endtask

task automatic upper_immediates();
    prog = {upper_insn(lui_opc, 5, 'h12345), upper_insn(lui_opc, 6, 'hfedcb),
            upper_insn(auipc_opc, 7, 'h00001), upper_insn(auipc_opc, 8, 'h80000),
            addi_insn(9, 6, -1), ebreak_insn};
    run_program(-1, 1'b0);
endtask

// R-type add and slti fall outside the subset and must not write x10
task automatic x0_and_unknown_ops();
    prog = {addi_insn(0, 0, 9), addi_insn(10, 0, 3), addi_insn(0, 10, 1),
            addi_insn(11, 0, 0), itype_insn(reg_opc, 0, 10, 11, 11),
            itype_insn(imm_opc, 2, 10, 10, 100), addi_insn(12, 10, 0), ebreak_insn};
    run_program(-1, 1'b0);
endtask

task automatic ebreak_stops_fetch();
    prog = {addi_insn(1, 0, 1), ebreak_insn, addi_insn(2, 0, 2)};
    run_program(-1, 1'b0);
endtask

task automatic bus_error_halts();
    prog = {addi_insn(1, 0, 11), addi_insn(2, 1, 22), addi_insn(3, 2, 33), ebreak_insn};
    run_program(2, 1'b0);
endtask

task automatic random_stalls_match();
    prog = {addi_insn(1, 0, 100), upper_insn(lui_opc, 2, 'habcde),
            upper_insn(auipc_opc, 3, 'h007ff), addi_insn(4, 1, -200),
            addi_insn(5, 2, 'h7ff), itype_insn(reg_opc, 0, 5, 4, 4), addi_insn(6, 5, -1),
            addi_insn(7, 3, 4), upper_insn(auipc_opc, 8, 'hfffff), addi_insn(9, 9, -5),
            ebreak_insn};
    run_program(-1, 1'b0);
    base_q = got_q;
    repeat (2) begin
        run_program(-1, 1'b1);
        foreach (base_q[i])
            assert (got_q[i] == base_q[i])
                else report_mismatch($sformatf("retire %0d differs from zero-delay run", i));
    end
endtask

// ==== tb_cpu.sv ====
`timescale 1ns/10ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int clk_period  = 4;
    localparam int drive_delay = 1;
    localparam int mem_idx_w   = 6;
    localparam int mem_words   = 1 << mem_idx_w;
    // Up to 4 cycles on each channel, plus execute and retire
    localparam int worst_inst_cycles = 12;
    localparam int total_insts       = 70;
    localparam int run_count         = 8;
    localparam int run_overhead      = 20;
    localparam int watchdog_ns       =
        2 * clk_period * (total_insts * worst_inst_cycles + run_count * run_overhead);

    logic        clk;
    logic        rst_n;
    logic        arready;
    axi_r_t      r;
    axi_ar_t     ar;
    logic        rready;
    retire_t     retire;
    logic        halted;
    halt_cause_e halt_cause;

    logic [xlen-1:0] mem [0:mem_words-1];
    logic [xlen-1:0] prog [$];
    logic [xlen-1:0] model_regs [0:31];
    retire_t         got_q [$];
    retire_t         exp_q [$];
    retire_t         base_q [$];
    integer          seed = 32'h5544_e6e9;
    bit              use_delays;
    bit              ar_after_halt;
    int              fetch_stop_count;
    int              err_index;
    int              errors;

    cpu_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .arready    (arready),
        .r          (r),
        .ar         (ar),
        .rready     (rready),
        .retire     (retire),
        .halted     (halted),
        .halt_cause (halt_cause)
    );

    `include "tb_tasks.svh"

    function automatic int pick_delay();
        if (!use_delays)
            return 0;
        return $random(seed) & 3;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // AXI4-Lite read slave with SLVERR on err_index and DECERR outside the memory
    initial begin
        bit              ar_hs;
        bit              r_hs;
        bit              ar_seen;
        bit              rst_seen;
        bit              rd_pending;
        int              ar_wait;
        int              rd_wait;
        logic [xlen-1:0] ar_addr;
        logic [xlen-1:0] off;
        arready    = 1'b0;
        r          = '0;
        rd_pending = 1'b0;
        ar_wait    = 0;
        rd_wait    = 0;
        off        = '0;
        forever begin
            @(negedge clk);
            ar_hs    = ar.valid && arready;
            r_hs     = r.valid && rready;
            ar_seen  = ar.valid;
            ar_addr  = ar.addr;
            rst_seen = rst_n;
            @(posedge clk);
            #drive_delay;
            if (!rst_seen) begin
                arready    = 1'b0;
                r          = '0;
                rd_pending = 1'b0;
                ar_wait    = pick_delay();
            end else begin
                if (ar_hs) begin
                    arready    = 1'b0;
                    off        = ar_addr - reset_pc;
                    rd_pending = 1'b1;
                    rd_wait    = pick_delay();
                    ar_wait    = pick_delay();
                end else if (ar_seen && !arready) begin
                    if (ar_wait == 0)
                        arready = 1'b1;
                    else
                        ar_wait--;
                end
                if (r_hs) begin
                    r.valid    = 1'b0;
                    rd_pending = 1'b0;
                end else if (rd_pending && !r.valid && rd_wait > 0) begin
                    rd_wait--;
                end else if (rd_pending && !r.valid) begin
                    r.valid = 1'b1;
                    r.data  = '0;
                    r.resp  = 2'b00;
                    if (off[1:0] != 2'b00 || off[xlen-1:mem_idx_w+2] != '0)
                        r.resp = 2'b11;
                    else if (int'(off[mem_idx_w+1:2]) == err_index)
                        r.resp = 2'b10;
                    else
                        r.data = mem[off[mem_idx_w+1:2]];
                end
            end
        end
    end

    // Retire and fetch monitor
    always @(negedge clk) begin
        if (rst_n) begin
            if (retire.valid)
                got_q.push_back(retire);
            // No fetch from the ebreak retire on
            if (ar.valid && (halted || got_q.size() == fetch_stop_count))
                ar_after_halt = 1'b1;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog: run did not finish within %0d ns", watchdog_ns);
        end_with_failure();
    end

    initial begin
        rst_n            = 1'b0;
        use_delays       = 1'b0;
        ar_after_halt    = 1'b0;
        fetch_stop_count = -1;
        err_index        = -1;
        errors           = 0;
        addi_chain();
        upper_immediates();
        x0_and_unknown_ops();
        ebreak_stops_fetch();
        bus_error_halts();
        random_stalls_match();
        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

// ==== verilog.f ====
+incdir+.
cpu_pkg.sv
ifu.sv
idu.sv
gpr_file.sv
exu.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= RESULT: FAIL
PASS_MSG  ?= RESULT: PASS

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := tb_tasks.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
